// ==== hdl/chdr_pkg.sv ====
// ######################################
// CHDR word format: widths, header struct,
// header/timestamp word union, packet type
// codes and header field helpers
// ######################################

package chdr_pkg;

  // the bus carries exactly one CHDR word per beat
  localparam int CHDR_W           = 64;
  localparam int CHDR_HEADER_W    = 64;
  localparam int CHDR_TIMESTAMP_W = 64;

  // only the two data packet types are produced in this subsystem
  typedef enum logic [2:0] {
    DATA_NO_TS = 3'd6,
    DATA_TS    = 3'd7
  } chdr_pkt_type_t;

  // field order follows the CHDR header from bit 63 down to bit 0
  typedef struct packed {
    logic [5:0]     vc;
    logic           eob;
    logic           eov;
    chdr_pkt_type_t pkt_type;
    logic [4:0]     num_mdata;
    logic [15:0]    seq_num;
    logic [15:0]    length;
    logic [15:0]    dst_epid;
  } chdr_header_t;

  // the first word of a packet is a header and the second one of a timed
  // packet is a timestamp, so one bus word is read either way
  typedef union packed {
    chdr_header_t                header;
    logic [CHDR_TIMESTAMP_W-1:0] timestamp;
  } chdr_word_u;

  // end-of-burst bit of a header word
  function automatic logic chdr_get_eob(input logic [CHDR_W-1:0] word);
    chdr_word_u w;
    w = word;
    return w.header.eob;
  endfunction

  // packet type field of a header word
  function automatic chdr_pkt_type_t chdr_get_pkt_type(input logic [CHDR_W-1:0] word);
    chdr_word_u w;
    w = word;
    return w.header.pkt_type;
  endfunction

endpackage

// ==== hdl/stream_ctrl_pkg.sv ====
// ######################################
// subsystem control and status types:
// generator burst config, monitor flags
// ######################################

package stream_ctrl_pkg;

  // one burst request, latched by the generator on its start pulse
  typedef struct packed {
    logic [7:0]  num_pkts;
    logic [7:0]  spp;
    logic        timed;
    logic [15:0] dst_epid;
    logic [63:0] start_time;
    logic [6:0]  pad;
  } gen_cfg_t;

  // everything the monitor reports about the current output transfer
  typedef struct packed {
    logic                                  xfer;
    logic                                  sop;
    logic                                  eop;
    logic                                  sob;
    logic                                  eob;
    logic                                  ts_known;
    chdr_pkg::chdr_header_t                header;
    logic [chdr_pkg::CHDR_TIMESTAMP_W-1:0] timestamp;
  } mon_flags_t;

endpackage

// ==== hdl/chdr_traffic_gen.sv ====
// ######################################
// CHDR traffic generator: bursts of data
// packets with counting payload on AXIS
// ######################################
`timescale 1ns/1ps

module chdr_traffic_gen (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         i_start,
  input  stream_ctrl_pkg::gen_cfg_t    i_cfg,
  output logic [chdr_pkg::CHDR_W-1:0]  o_tdata,
  output logic                         o_tlast,
  output logic                         o_tvalid,
  input  logic                         i_tready,
  output logic                         o_busy
);
  import chdr_pkg::*;
  import stream_ctrl_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEADER,
    ST_TS,
    ST_PAYLOAD
  } state_t;

  state_t      state;
  gen_cfg_t    cfg_reg;
  logic [15:0] seq_num;
  logic [7:0]  pkt_idx;
  logic [7:0]  word_idx;
  logic [63:0] ts_reg;
  chdr_word_u  word;
  logic        xfer;
  logic        last_pkt;
  logic        last_word;

  assign xfer      = o_tvalid && i_tready;
  assign last_pkt  = (pkt_idx == cfg_reg.num_pkts - 8'd1);
  assign last_word = (word_idx == cfg_reg.spp - 8'd1);

  // outputs come straight from state and counters, which only move on a
  // transfer, so a stalled word stays put without extra holding registers
  assign o_tvalid = (state != ST_IDLE);
  assign o_busy   = (state != ST_IDLE);
  assign o_tlast  = (state == ST_PAYLOAD) && last_word;
  assign o_tdata  = word;

  always_comb begin
    word = '0;
    case (state)
      ST_HEADER: begin
        // vc, eov and num_mdata stay zero
        word.header.eob      = last_pkt;
        word.header.pkt_type = cfg_reg.timed ? DATA_TS : DATA_NO_TS;
        word.header.seq_num  = seq_num;
        // length in bytes covers header, optional timestamp and payload
        word.header.length   = (16'(cfg_reg.spp) + 16'(cfg_reg.timed) + 16'd1) << 3;
        word.header.dst_epid = cfg_reg.dst_epid;
      end
      ST_TS: begin
        word.timestamp = ts_reg;
      end
      ST_PAYLOAD: begin
        // upper half is the packet's sequence number, lower half counts words
        word = {16'd0, seq_num, 24'd0, word_idx};
      end
      default: begin
        word = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      seq_num  <= '0;
      pkt_idx  <= '0;
      word_idx <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // a start pulse while busy never reaches here, so it is dropped
          if (i_start) begin
            pkt_idx  <= '0;
            word_idx <= '0;
            state    <= ST_HEADER;
          end
        end
        ST_HEADER: begin
          if (xfer) begin
            word_idx <= '0;
            state    <= cfg_reg.timed ? ST_TS : ST_PAYLOAD;
          end
        end
        ST_TS: begin
          if (xfer) state <= ST_PAYLOAD;
        end
        ST_PAYLOAD: begin
          if (xfer) begin
            if (last_word) begin
              // sequence number keeps running across bursts
              seq_num  <= seq_num + 16'd1;
              word_idx <= '0;
              if (last_pkt) begin
                state <= ST_IDLE;
              end else begin
                pkt_idx <= pkt_idx + 8'd1;
                state   <= ST_HEADER;
              end
            end else begin
              word_idx <= word_idx + 8'd1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // burst config and first timestamp load on the start pulse
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && i_start) begin
      cfg_reg <= i_cfg;
      ts_reg  <= i_cfg.start_time;
    end else if (state == ST_PAYLOAD && xfer && last_word) begin
      // next packet's time is spp samples later
      ts_reg <= ts_reg + 64'(cfg_reg.spp);
    end
  end

  // a stalled word must be held unchanged until the sink takes it
  a_hold_stalled_word: assert property (
    @(posedge clk) disable iff (rst)
    (o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast))
  );

endmodule

// ==== hdl/chdr_fifo.sv ====
// ######################################
// synchronous AXI-Stream FIFO for CHDR
// words together with tlast
// ######################################
`timescale 1ns/1ps

module chdr_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [chdr_pkg::CHDR_W-1:0] i_tdata,
  input  logic                        i_tlast,
  input  logic                        i_tvalid,
  output logic                        o_tready,
  output logic [chdr_pkg::CHDR_W-1:0] o_tdata,
  output logic                        o_tlast,
  output logic                        o_tvalid,
  input  logic                        i_tready
);
  import chdr_pkg::*;

  localparam logic [FIFO_DEPTH_LOG2:0] DEPTH = 1 << FIFO_DEPTH_LOG2;

  // each entry stores tlast above the data word
  logic [CHDR_W:0]              mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0]   wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0]   rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]     count;
  logic                         wr_en;
  logic                         rd_en;

  assign o_tready = (count != DEPTH);
  assign o_tvalid = (count != '0);
  assign wr_en    = i_tvalid && o_tready;
  assign rd_en    = o_tvalid && i_tready;

  // head of the queue is shown without a read register
  assign {o_tlast, o_tdata} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= {i_tlast, i_tdata};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own since the depth is a power of two
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // with equal pointers the buffer is either empty or full, so a write
  // there must see it empty and never overwrite the unread head
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> (wr_ptr != rd_ptr || count == '0)
  );
  // a read from equal pointers is only legal when every slot holds a word
  a_no_read_when_empty: assert property (
    @(posedge clk) disable iff (rst) rd_en |-> (wr_ptr != rd_ptr || count == DEPTH)
  );

endmodule

// ==== hdl/axis_monitor.sv ====
// ######################################
// generic AXI-Stream monitor: transfer,
// sop/eop strobes, transfer/packet counts
// ######################################
`timescale 1ns/1ps

module axis_monitor #(
  parameter int COUNT_W = 32
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_tlast,
  input  logic               i_tvalid,
  input  logic               i_tready,
  output logic               o_xfer,
  output logic               o_sop,
  output logic               o_eop,
  output logic [COUNT_W-1:0] o_xfer_count,
  output logic [COUNT_W-1:0] o_pkt_count
);

  // high between the first and last transfer of a packet
  logic in_pkt;

  assign o_xfer = i_tvalid && i_tready;
  assign o_sop  = o_xfer && !in_pkt;
  assign o_eop  = o_xfer && i_tlast;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt       <= 1'b0;
      o_xfer_count <= '0;
      o_pkt_count  <= '0;
    end else if (o_xfer) begin
      in_pkt       <= !i_tlast;
      o_xfer_count <= o_xfer_count + 1'b1;
      if (i_tlast) o_pkt_count <= o_pkt_count + 1'b1;
    end
  end

  // strobes only ever mark an actual transfer
  a_strobe_on_xfer: assert property (
    @(posedge clk) disable iff (rst) (o_sop || o_eop) |-> o_xfer
  );

endmodule

// ==== hdl/chdr_monitor.sv ====
// ######################################
// CHDR monitor: burst strobes and count,
// header and timestamp of current packet
// ######################################
`timescale 1ns/1ps

module chdr_monitor #(
  parameter int COUNT_W = 32
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [chdr_pkg::CHDR_W-1:0] i_tdata,
  input  logic                        i_tlast,
  input  logic                        i_tvalid,
  input  logic                        i_tready,
  output stream_ctrl_pkg::mon_flags_t o_flags,
  output logic [COUNT_W-1:0]          o_xfer_count,
  output logic [COUNT_W-1:0]          o_pkt_count,
  output logic [COUNT_W-1:0]          o_burst_count
);
  import chdr_pkg::*;
  import stream_ctrl_pkg::*;

  logic                        xfer;
  logic                        sop;
  logic                        eop;
  logic                        sob;
  logic                        eob;
  chdr_word_u                  bus_word;
  logic                        has_time;
  logic                        second_xfer;
  // the first packet after reset opens a burst
  logic                        pkt_is_sob;
  logic                        pkt_is_eob;
  logic                        pkt_is_timed;
  logic                        sop_done;
  chdr_header_t                header_reg;
  logic [CHDR_TIMESTAMP_W-1:0] ts_reg;
  logic                        ts_known_reg;

  axis_monitor #(
    .COUNT_W(COUNT_W)
  ) axis_monitor_inst (
    .clk         (clk),
    .rst         (rst),
    .i_tlast     (i_tlast),
    .i_tvalid    (i_tvalid),
    .i_tready    (i_tready),
    .o_xfer      (xfer),
    .o_sop       (sop),
    .o_eop       (eop),
    .o_xfer_count(o_xfer_count),
    .o_pkt_count (o_pkt_count)
  );

  assign bus_word = i_tdata;
  assign has_time = (chdr_get_pkt_type(i_tdata) == DATA_TS);

  // sop_done is set only between the header and the next transfer
  assign second_xfer = xfer && sop_done;

  assign sob = sop && pkt_is_sob;
  // a one-word packet carries its eob in the header on the bus right now
  assign eob = eop && (sop ? chdr_get_eob(i_tdata) : pkt_is_eob);

  always_comb begin
    o_flags.xfer   = xfer;
    o_flags.sop    = sop;
    o_flags.eop    = eop;
    o_flags.sob    = sob;
    o_flags.eob    = eob;
    o_flags.header = sop ? bus_word.header : header_reg;
    // timestamp is passed through on the second word and held afterwards
    if (second_xfer && pkt_is_timed) begin
      o_flags.timestamp = bus_word.timestamp;
      o_flags.ts_known  = 1'b1;
    end else begin
      o_flags.timestamp = ts_reg;
      o_flags.ts_known  = ts_known_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_is_sob    <= 1'b1;
      pkt_is_eob    <= 1'b0;
      pkt_is_timed  <= 1'b0;
      sop_done      <= 1'b0;
      header_reg    <= '0;
      ts_reg        <= '0;
      ts_known_reg  <= 1'b0;
      o_burst_count <= '0;
    end else begin
      if (sop) begin
        header_reg   <= bus_word.header;
        pkt_is_eob   <= chdr_get_eob(i_tdata);
        pkt_is_timed <= has_time;
        pkt_is_sob   <= 1'b0;
        sop_done     <= !eop;
      end else if (xfer) begin
        sop_done <= 1'b0;
      end
      if (second_xfer && pkt_is_timed) begin
        ts_reg       <= bus_word.timestamp;
        ts_known_reg <= 1'b1;
      end
      // nothing of the finished packet survives past its last word
      if (eop) begin
        header_reg   <= '0;
        ts_reg       <= '0;
        ts_known_reg <= 1'b0;
      end
      // the packet after an eob opens a new burst
      if (eob) begin
        pkt_is_sob    <= 1'b1;
        o_burst_count <= o_burst_count + 1'b1;
      end
    end
  end

  // a burst can only open on the first word of a packet from axis_monitor
  a_sob_on_sop: assert property (
    @(posedge clk) disable iff (rst) sob |-> sop
  );

endmodule

// ==== hdl/chdr_stream_top.sv ====
// ######################################
// CHDR stream top: generator, FIFO and
// output monitor
// ######################################
`timescale 1ns/1ps

module chdr_stream_top #(
  parameter int COUNT_W         = 32,
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_start,
  input  stream_ctrl_pkg::gen_cfg_t   i_cfg,
  output logic                        o_busy,
  output logic [chdr_pkg::CHDR_W-1:0] o_out_tdata,
  output logic                        o_out_tlast,
  output logic                        o_out_tvalid,
  input  logic                        i_out_tready,
  output stream_ctrl_pkg::mon_flags_t o_flags,
  output logic [COUNT_W-1:0]          o_xfer_count,
  output logic [COUNT_W-1:0]          o_pkt_count,
  output logic [COUNT_W-1:0]          o_burst_count
);
  import chdr_pkg::*;

  // generator to FIFO stream
  logic [CHDR_W-1:0] gen_tdata;
  logic              gen_tlast;
  logic              gen_tvalid;
  logic              gen_tready;

  chdr_traffic_gen chdr_traffic_gen_inst (
    .clk     (clk),
    .rst     (rst),
    .i_start (i_start),
    .i_cfg   (i_cfg),
    .o_tdata (gen_tdata),
    .o_tlast (gen_tlast),
    .o_tvalid(gen_tvalid),
    .i_tready(gen_tready),
    .o_busy  (o_busy)
  );

  chdr_fifo #(
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
  ) chdr_fifo_inst (
    .clk     (clk),
    .rst     (rst),
    .i_tdata (gen_tdata),
    .i_tlast (gen_tlast),
    .i_tvalid(gen_tvalid),
    .o_tready(gen_tready),
    .o_tdata (o_out_tdata),
    .o_tlast (o_out_tlast),
    .o_tvalid(o_out_tvalid),
    .i_tready(i_out_tready)
  );

  // the monitor only listens to the output port
  chdr_monitor #(
    .COUNT_W(COUNT_W)
  ) chdr_monitor_inst (
    .clk          (clk),
    .rst          (rst),
    .i_tdata      (o_out_tdata),
    .i_tlast      (o_out_tlast),
    .i_tvalid     (o_out_tvalid),
    .i_tready     (i_out_tready),
    .o_flags      (o_flags),
    .o_xfer_count (o_xfer_count),
    .o_pkt_count  (o_pkt_count),
    .o_burst_count(o_burst_count)
  );

endmodule

// ==== tests/tb_chdr_stream.sv ====
// ######################################
// testbench for chdr_stream_top: model of
// the packet format, stimulus, compare
// process and cycle watchdog
// ######################################
`timescale 1ns/1ps

module tb_chdr_stream;
  import chdr_pkg::*;
  import stream_ctrl_pkg::*;

  localparam int COUNT_W         = 32;
  // a small FIFO so random tready really fills it
  localparam int FIFO_DEPTH_LOG2 = 2;

  logic               clk;
  logic               rst;
  logic               i_start;
  gen_cfg_t           i_cfg;
  logic               i_out_tready = 1'b1;
  logic               o_busy;
  logic [CHDR_W-1:0]  o_out_tdata;
  logic               o_out_tlast;
  logic               o_out_tvalid;
  mon_flags_t         o_flags;
  logic [COUNT_W-1:0] o_xfer_count;
  logic [COUNT_W-1:0] o_pkt_count;
  logic [COUNT_W-1:0] o_burst_count;

  int       seed = 35;
  logic     random_ready = 1'b0;
  int       pass_count = 0;
  int       error_count = 0;
  int       cycle_count = 0;
  int       cycle_limit = 0;
  // bursts still expected on the output, with the seq_num of their first packet
  gen_cfg_t exp_cfg[$];
  int       exp_base[$];
  int       cur_pkt = 0;
  int       cur_word = 0;
  int       bursts_seen = 0;
  int       seq_next = 0;
  int       total_words = 0;
  int       total_pkts = 0;
  int       total_bursts = 0;
  // scratch state of the compare process
  gen_cfg_t    cmp_cfg;
  logic [64:0] cmp_word;
  logic [64:0] cmp_hdr;
  logic        cmp_sop;
  logic        cmp_eop;
  logic        cmp_ts_known;
  gen_cfg_t    cfg_a;
  gen_cfg_t    cfg_b;
  gen_cfg_t    cfg_c;
  gen_cfg_t    cfg_d;
  gen_cfg_t    cfg_e;
  int          errors_before;

  chdr_stream_top #(
    .COUNT_W        (COUNT_W),
    .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
  ) chdr_stream_top_inst (
    .clk          (clk),
    .rst          (rst),
    .i_start      (i_start),
    .i_cfg        (i_cfg),
    .o_busy       (o_busy),
    .o_out_tdata  (o_out_tdata),
    .o_out_tlast  (o_out_tlast),
    .o_out_tvalid (o_out_tvalid),
    .i_out_tready (i_out_tready),
    .o_flags      (o_flags),
    .o_xfer_count (o_xfer_count),
    .o_pkt_count  (o_pkt_count),
    .o_burst_count(o_burst_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic gen_cfg_t make_cfg(input logic [7:0] num_pkts, input logic [7:0] spp,
                                        input logic timed, input logic [15:0] dst_epid,
                                        input logic [63:0] start_time);
    gen_cfg_t cfg;
    cfg            = '0;
    cfg.num_pkts   = num_pkts;
    cfg.spp        = spp;
    cfg.timed      = timed;
    cfg.dst_epid   = dst_epid;
    cfg.start_time = start_time;
    return cfg;
  endfunction

  // header, optional timestamp, then spp payload words
  function automatic int words_per_pkt(input gen_cfg_t cfg);
    return 1 + (cfg.timed ? 1 : 0) + int'(cfg.spp);
  endfunction

  function automatic int words_in_burst(input gen_cfg_t cfg);
    return int'(cfg.num_pkts) * words_per_pkt(cfg);
  endfunction

  // expected {tlast, tdata} for one word of a burst
  function automatic logic [64:0] chdr_expected_word(input gen_cfg_t cfg, input int seq_base,
                                                     input int pkt_idx, input int word_idx);
    chdr_header_t hdr;
    logic [15:0]  seq;
    int           ts_words;
    int           k;
    logic [64:0]  result;
    seq      = 16'(seq_base + pkt_idx);
    ts_words = cfg.timed ? 1 : 0;
    if (word_idx == 0) begin
      hdr          = '0;
      hdr.eob      = (pkt_idx == int'(cfg.num_pkts) - 1);
      hdr.pkt_type = cfg.timed ? DATA_TS : DATA_NO_TS;
      hdr.seq_num  = seq;
      hdr.length   = 16'(8 * (1 + ts_words + int'(cfg.spp)));
      hdr.dst_epid = cfg.dst_epid;
      result       = {1'b0, hdr};
    end else if (word_idx == 1 && cfg.timed) begin
      result = {1'b0, cfg.start_time + 64'(pkt_idx) * 64'(cfg.spp)};
    end else begin
      // payload carries the seq_num on top and the word count below
      k      = word_idx - 1 - ts_words;
      result = {(k == int'(cfg.spp) - 1), 16'd0, seq, 32'(k)};
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
      error_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (error_count == errs_at_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, error_count - errs_at_start);
    end
  endtask

  // pulses i_start and queues the burst for the compare process
  task automatic start_burst(input gen_cfg_t cfg);
    @(negedge clk);
    i_cfg   = cfg;
    i_start = 1'b1;
    exp_cfg.push_back(cfg);
    exp_base.push_back(seq_next);
    seq_next     = seq_next + int'(cfg.num_pkts);
    total_words  = total_words + words_in_burst(cfg);
    total_pkts   = total_pkts + int'(cfg.num_pkts);
    total_bursts = total_bursts + 1;
    @(negedge clk);
    i_start = 1'b0;
  endtask

  task automatic wait_burst_done(input int target);
    while (bursts_seen < target) @(negedge clk);
  endtask

  // tready is either random or held high, always changed on the falling edge
  always @(negedge clk) begin
    if (random_ready) begin
      i_out_tready <= (($random(seed) & 1) != 0);
    end else begin
      i_out_tready <= 1'b1;
    end
  end

  // the compare process samples on the rising edge, where the bus is settled
  always @(posedge clk) begin
    if (!rst) begin
      if (o_out_tvalid && i_out_tready) begin
        if (exp_cfg.size() == 0) begin
          $display("transfer of word 0x%0h arrived while no burst was expected", o_out_tdata);
          error_count++;
        end else begin
          cmp_cfg      = exp_cfg[0];
          cmp_word     = chdr_expected_word(cmp_cfg, exp_base[0], cur_pkt, cur_word);
          cmp_hdr      = chdr_expected_word(cmp_cfg, exp_base[0], cur_pkt, 0);
          cmp_sop      = (cur_word == 0);
          cmp_eop      = (cur_word == words_per_pkt(cmp_cfg) - 1);
          cmp_ts_known = cmp_cfg.timed && (cur_word >= 1);
          check_value("o_out_tdata", cmp_word[63:0], o_out_tdata);
          check_value("o_out_tlast", 64'(cmp_word[64]), 64'(o_out_tlast));
          check_value("o_flags.xfer", 64'd1, 64'(o_flags.xfer));
          check_value("o_flags.sop", 64'(cmp_sop), 64'(o_flags.sop));
          check_value("o_flags.eop", 64'(cmp_eop), 64'(o_flags.eop));
          check_value("o_flags.sob", 64'(cmp_sop && cur_pkt == 0), 64'(o_flags.sob));
          check_value("o_flags.eob", 64'(cmp_eop && cur_pkt == int'(cmp_cfg.num_pkts) - 1),
                      64'(o_flags.eob));
          check_value("o_flags.header", cmp_hdr[63:0], 64'(o_flags.header));
          check_value("o_flags.ts_known", 64'(cmp_ts_known), 64'(o_flags.ts_known));
          if (cmp_ts_known) begin
            cmp_word = chdr_expected_word(cmp_cfg, exp_base[0], cur_pkt, 1);
            check_value("o_flags.timestamp", cmp_word[63:0], o_flags.timestamp);
          end
          // step through word, packet and burst
          if (cmp_eop) begin
            cur_word = 0;
            if (cur_pkt == int'(cmp_cfg.num_pkts) - 1) begin
              cur_pkt = 0;
              void'(exp_cfg.pop_front());
              void'(exp_base.pop_front());
              bursts_seen++;
            end else begin
              cur_pkt++;
            end
          end else begin
            cur_word++;
          end
        end
      end else begin
        check_value("o_flags strobes", 64'd0,
                    64'({o_flags.xfer, o_flags.sop, o_flags.eop, o_flags.sob, o_flags.eob}));
        // between packets nothing of a timestamp may be claimed
        if (cur_word == 0) check_value("o_flags.ts_known", 64'd0, 64'(o_flags.ts_known));
      end
    end
  end

  // watchdog on the whole run
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rst     = 1'b1;
    i_start = 1'b0;
    cfg_a   = make_cfg(8'd3, 8'd4, 1'b0, 16'h0123, 64'd0);
    cfg_b   = make_cfg(8'd2, 8'd2, 1'b1, 16'h0456, 64'h0000_0010_0000_0100);
    cfg_c   = make_cfg(8'd4, 8'd5, 1'b1, 16'h0789, 64'h0000_00ab_cdef_0000);
    cfg_d   = make_cfg(8'd2, 8'd3, 1'b0, 16'h0abc, 64'd0);
    // this one is pulsed while busy and must never show up
    cfg_e   = make_cfg(8'd5, 8'd6, 1'b1, 16'h0def, 64'h1234);
    i_cfg   = '0;
    cycle_limit = 4 * (words_in_burst(cfg_a) + words_in_burst(cfg_b) +
                       words_in_burst(cfg_c) + words_in_burst(cfg_d)) + 200;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    errors_before = error_count;
    @(negedge clk);
    check_value("o_out_tvalid", 64'd0, 64'(o_out_tvalid));
    check_value("o_busy", 64'd0, 64'(o_busy));
    check_value("o_flags strobes", 64'd0,
                64'({o_flags.xfer, o_flags.sop, o_flags.eop, o_flags.sob, o_flags.eob,
                     o_flags.ts_known}));
    check_value("o_xfer_count", 64'd0, 64'(o_xfer_count));
    check_value("o_pkt_count", 64'd0, 64'(o_pkt_count));
    check_value("o_burst_count", 64'd0, 64'(o_burst_count));
    report_test("test 1 reset state", errors_before);

    errors_before = error_count;
    start_burst(cfg_a);
    wait_burst_done(1);
    report_test("test 2 untimed burst", errors_before);

    errors_before = error_count;
    start_burst(cfg_b);
    wait_burst_done(2);
    report_test("test 3 timed burst", errors_before);

    errors_before = error_count;
    random_ready = 1'b1;
    start_burst(cfg_c);
    wait_burst_done(3);
    random_ready = 1'b0;
    report_test("test 4 timed burst with random tready", errors_before);

    errors_before = error_count;
    start_burst(cfg_d);
    repeat (2) @(negedge clk);
    if (!o_busy) begin
      $display("generator was already idle when the second start pulse was due");
      error_count++;
    end
    i_cfg   = cfg_e;
    i_start = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    wait_burst_done(4);
    // leave time for any stray word to reach the compare process
    repeat (10) @(negedge clk);
    check_value("o_busy", 64'd0, 64'(o_busy));
    report_test("test 5 start pulse while busy", errors_before);

    errors_before = error_count;
    check_value("o_xfer_count", 64'(total_words), 64'(o_xfer_count));
    check_value("o_pkt_count", 64'(total_pkts), 64'(o_pkt_count));
    check_value("o_burst_count", 64'(total_bursts), 64'(o_burst_count));
    report_test("test 6 final counts", errors_before);

    $display("checks passed: %0d, errors: %0d", pass_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/chdr_pkg.sv
hdl/stream_ctrl_pkg.sv
hdl/chdr_traffic_gen.sv
hdl/chdr_fifo.sv
hdl/axis_monitor.sv
hdl/chdr_monitor.sv
hdl/chdr_stream_top.sv
tests/tb_chdr_stream.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the CHDR stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_chdr_stream \
  -o sim_chdr_stream
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_chdr_stream)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" <<< "$output"; then
  exit 0
fi
exit 1
